// File: glb_tile.f
+incdir+rtl
rtl/glb_pkg.sv
rtl/glb_tile_cfg.sv
rtl/glb_store_dma.sv
rtl/glb_bank.sv
rtl/glb_tile.sv
test/glb_tile_tb.sv

// File: Makefile
.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f glb_tile.f --top-module glb_tile_tb
	verilator --lint-only -f glb_tile.f --top-module glb_tile

sim:
	verilator --binary --timing --assert -f glb_tile.f --top-module glb_tile_tb -Mdir obj_dir
	./obj_dir/Vglb_tile_tb | tee sim.log
	grep -q "TEST RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

// File: test/glb_tile_tb.sv
// Testbench for one tile with id 3. The testbench models the west neighbour.
// All inputs change on the falling clock edge and outputs are checked there too.
`timescale 1ns/1ps
`default_nettype none
`include "glb_consts.svh"

module glb_tile_tb
    import glb_pkg::*;
();

    localparam tile_id_t TILE = 4'd3;
    localparam tile_id_t OTHER = 4'd5;
    localparam int MAX_CYCLES = 4000;

    logic       clk = 1'b0;
    logic       reset = 1'b1;
    cfg_req_t   cfg_east_req;
    cfg_rsp_t   cfg_east_rsp;
    cfg_req_t   cfg_west_req;
    cfg_rsp_t   cfg_west_rsp = '0;
    cfg_rsp_t   west_pend = '0;
    logic       tile_is_start;
    logic       tile_is_end;
    logic       st_valid;
    logic       st_ready;
    data_t      st_data;
    logic       rd_req_valid;
    logic       rd_req_ready;
    bank_addr_t rd_req_addr;
    data_t      rd_data;
    logic       rd_valid;
    data_t      mem_model [256];
    cfg_data_t  reg_model [10];
    int         cycles = 0;
    int         checks = 0;
    int         errors = 0;

    glb_tile dut (
        .clk, .reset, .glb_tile_id(TILE), .cfg_east_req, .cfg_east_rsp, .cfg_west_req,
        .cfg_west_rsp, .tile_is_start, .tile_is_end, .st_valid, .st_ready, .st_data,
        .rd_req_valid, .rd_req_ready, .rd_req_addr, .rd_data, .rd_valid
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == MAX_CYCLES) begin
            $display("Timeout after %0d cycles, the DUT stopped making progress.", cycles);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    // West neighbour answers a forwarded read one cycle after it sees it.
    always @(negedge clk) begin
        cfg_west_rsp <= west_pend;
        west_pend.rd_data <= cfg_data_t'(cfg_west_req.rd_addr) + 32'h100;
        west_pend.rd_data_valid <= cfg_west_req.rd_en;
    end

    a_local_rd: assert property (@(posedge clk) disable iff (reset)
        (cfg_east_req.rd_en && cfg_east_req.rd_addr[10:7] == TILE) |=>
        cfg_east_rsp.rd_data_valid)
        else begin
            errors++;
            $display("Local read response missing at %0t.", $time);
        end
    a_fwd_wr: assert property (@(posedge clk) disable iff (reset)
        (cfg_east_req.wr_en && cfg_east_req.wr_addr[10:7] != TILE) |=>
        (cfg_west_req.wr_en && cfg_west_req.wr_addr == $past(cfg_east_req.wr_addr)
         && cfg_west_req.wr_data == $past(cfg_east_req.wr_data)))
        else begin
            errors++;
            $display("Write not forwarded west at %0t.", $time);
        end
    a_remote_rd: assert property (@(posedge clk) disable iff (reset)
        (cfg_east_req.rd_en && cfg_east_req.rd_addr[10:7] != TILE) |-> ##3
        (cfg_east_rsp.rd_data_valid &&
         cfg_east_rsp.rd_data == cfg_data_t'($past(cfg_east_req.rd_addr, 3)) + 32'h100))
        else begin
            errors++;
            $display("Remote read response wrong at %0t.", $time);
        end
    a_host_rsp: assert property (@(posedge clk) disable iff (reset)
        (rd_req_valid && rd_req_ready) |=> rd_valid)
        else begin
            errors++;
            $display("Host read data late at %0t.", $time);
        end
    a_port_busy: assert property (@(posedge clk) disable iff (reset)
        (st_valid && st_ready) |-> !rd_req_ready)
        else begin
            errors++;
            $display("Host read ready during a write at %0t.", $time);
        end

    task automatic check_value(input string name, input logic [31:0] act,
                               input logic [31:0] exp);
        checks++;
        assert (act === exp) else begin
            errors++;
            $display("ERR t=%0t %s expected=%h actual=%h", $time, name, exp, act);
        end
    endtask

    function automatic cfg_addr_t reg_addr(input tile_id_t tile, input int r);
        reg_addr = {tile, 5'(r), 2'b00};
    endfunction

    function automatic cfg_data_t field_mask(input int r);
        if (r < 2) field_mask = 32'h3;
        else if (r % 2 == 0) field_mask = 32'hff;
        else field_mask = 32'h1ff;
    endfunction

    task automatic cfg_write(input tile_id_t tile, input int r, input cfg_data_t data);
        cfg_east_req = '0;
        cfg_east_req.wr_en = 1'b1;
        cfg_east_req.wr_addr = reg_addr(tile, r);
        cfg_east_req.wr_data = data;
        @(negedge clk);
        cfg_east_req = '0;
    endtask

    task automatic cfg_read_check(input int r, input cfg_data_t exp);
        cfg_east_req = '0;
        cfg_east_req.rd_en = 1'b1;
        cfg_east_req.rd_addr = reg_addr(TILE, r);
        @(negedge clk);
        cfg_east_req = '0;
        check_value("cfg_east_rsp.rd_data_valid", 32'(cfg_east_rsp.rd_data_valid), 1);
        check_value("cfg_east_rsp.rd_data", cfg_east_rsp.rd_data, exp);
    endtask

    task automatic remote_read(input int r);
        cfg_east_req = '0;
        cfg_east_req.rd_en = 1'b1;
        cfg_east_req.rd_addr = reg_addr(OTHER, r);
        @(negedge clk);
        cfg_east_req = '0;
        check_value("cfg_west_req.rd_en", 32'(cfg_west_req.rd_en), 1);
        check_value("cfg_west_req.rd_addr", 32'(cfg_west_req.rd_addr),
                    32'(reg_addr(OTHER, r)));
        repeat (2) @(negedge clk);
        check_value("cfg_east_rsp.rd_data_valid", 32'(cfg_east_rsp.rd_data_valid), 1);
        check_value("cfg_east_rsp.rd_data", cfg_east_rsp.rd_data,
                    cfg_data_t'(reg_addr(OTHER, r)) + 32'h100);
    endtask

    // Sends n random words with random gaps. Word i belongs at base + i.
    task automatic stream_words(input bank_addr_t base, input int n);
        int gap;
        for (int i = 0; i < n; i++) begin
            gap = $urandom_range(2, 0);
            repeat (gap) @(negedge clk);
            st_valid = 1'b1;
            st_data = data_t'($urandom);
            while (!st_ready) @(negedge clk);
            @(negedge clk);
            mem_model[base + bank_addr_t'(i)] = st_data;
            st_valid = 1'b0;
        end
    endtask

    task automatic host_read(input bank_addr_t addr);
        @(negedge clk);
        rd_req_valid = 1'b1;
        rd_req_addr = addr;
        #1;
        while (!rd_req_ready) begin
            @(negedge clk);
            #1;
        end
        @(negedge clk);
        rd_req_valid = 1'b0;
        check_value("rd_valid", 32'(rd_valid), 1);
        check_value("rd_data", 32'(rd_data), 32'(mem_model[addr]));
    endtask

    task automatic test_done(input int num, input string name);
        $display("Test %0d (%s) finished, %0d errors so far.", num, name, errors);
    endtask

    initial begin
        void'($urandom(32'ha394_bc46));
        cfg_east_req = '0;
        st_valid = 1'b0;
        st_data = '0;
        rd_req_valid = 1'b0;
        rd_req_addr = '0;
        repeat (16) @(negedge clk);
        reset = 1'b0;
        check_value("cfg_west_req", 32'(cfg_west_req == '0), 1);
        check_value("cfg_east_rsp.rd_data_valid", 32'(cfg_east_rsp.rd_data_valid), 0);
        check_value("tile_is_start", 32'(tile_is_start), 0);
        check_value("tile_is_end", 32'(tile_is_end), 0);
        check_value("st_ready", 32'(st_ready), 0);
        check_value("rd_valid", 32'(rd_valid), 0);
        test_done(1, "reset values");

        for (int r = 0; r < 10; r++) begin
            reg_model[r] = $urandom & field_mask(r);
            if (r == 1) reg_model[r] = reg_model[r] & 32'h2; // DMA stays off here.
            cfg_write(TILE, r, $urandom & ~field_mask(r) | reg_model[r]);
            if (r == 0) begin
                check_value("tile_is_start", 32'(tile_is_start), 32'(reg_model[0][0]));
                check_value("tile_is_end", 32'(tile_is_end), 32'(reg_model[0][1]));
            end
        end
        for (int r = 0; r < 10; r++) cfg_read_check(r, reg_model[r]);
        for (int r = 0; r < 10; r++) cfg_write(TILE, r, 0);
        test_done(2, "register readback");

        cfg_write(OTHER, 4, 32'hcafe_0042);
        check_value("cfg_west_req.wr_en", 32'(cfg_west_req.wr_en), 1);
        check_value("cfg_west_req.wr_data", cfg_west_req.wr_data, 32'hcafe_0042);
        remote_read(6);
        test_done(3, "west forwarding");

        cfg_write(TILE, 2, 8);
        cfg_write(TILE, 3, 32'h41);
        cfg_write(TILE, 1, 1);
        stream_words(8'h20, 8);
        repeat (3) @(negedge clk);
        for (int i = 0; i < 8; i++) host_read(8'h20 + 8'(i));
        cfg_read_check(3, 32'h40);
        test_done(4, "single store");

        cfg_write(TILE, 4, 5);
        cfg_write(TILE, 5, 32'hc1);
        cfg_write(TILE, 2, 3);
        cfg_write(TILE, 3, 32'h61);
        stream_words(8'h30, 3);
        repeat (3) @(negedge clk);
        for (int i = 0; i < 5; i++) begin
            check_value("st_ready", 32'(st_ready), 0);
            @(negedge clk);
        end
        cfg_read_check(3, 32'h60);
        cfg_read_check(5, 32'hc1);
        cfg_write(TILE, 1, 3);
        cfg_write(TILE, 2, 4);
        cfg_write(TILE, 3, 32'h81);
        stream_words(8'h40, 4);
        stream_words(8'h60, 5);
        repeat (3) @(negedge clk);
        cfg_read_check(3, 32'h80);
        cfg_read_check(5, 32'hc0);
        for (int i = 0; i < 4; i++) host_read(8'h40 + 8'(i));
        for (int i = 0; i < 5; i++) host_read(8'h60 + 8'(i));
        test_done(5, "queue order");

        cfg_write(TILE, 6, 6);
        cfg_write(TILE, 7, 32'h101);
        fork
            stream_words(8'h80, 6);
            for (int i = 0; i < 8; i++) host_read(8'h20 + 8'(i));
        join
        repeat (3) @(negedge clk);
        for (int i = 0; i < 6; i++) host_read(8'h80 + 8'(i));
        cfg_read_check(7, 32'h100);
        test_done(6, "reads during stream");

        $display("Checks: %0d, errors: %0d, cycles: %0d.", checks, errors, cycles);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: rtl/glb_tile.sv
// One global buffer tile. The west port connects to the next tile in the chain.
`timescale 1ns/1ps
`default_nettype none
`include "glb_consts.svh"

module glb_tile
    import glb_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  tile_id_t   glb_tile_id,
    input  cfg_req_t   cfg_east_req,
    output cfg_rsp_t   cfg_east_rsp,
    output cfg_req_t   cfg_west_req,
    input  cfg_rsp_t   cfg_west_rsp,
    output logic       tile_is_start,
    output logic       tile_is_end,
    input  logic       st_valid,
    output logic       st_ready,
    input  data_t      st_data,
    input  logic       rd_req_valid,
    output logic       rd_req_ready,
    input  bank_addr_t rd_req_addr,
    output data_t      rd_data,
    output logic       rd_valid
);

    logic                        dma_on;
    logic                        dma_auto_on;
    dma_header_t                 dma_header [`GLB_QUEUE_DEPTH];
    logic [`GLB_QUEUE_DEPTH-1:0] dma_invalidate;
    bank_wr_t                    bank_wr;

    glb_tile_cfg u_cfg (
        .clk, .reset, .glb_tile_id, .cfg_east_req, .cfg_east_rsp, .cfg_west_req,
        .cfg_west_rsp, .tile_is_start, .tile_is_end, .dma_on, .dma_auto_on,
        .dma_header, .dma_invalidate
    );

    glb_store_dma u_store_dma (
        .clk, .reset, .dma_on, .dma_auto_on, .dma_header, .st_valid, .st_data,
        .st_ready, .dma_invalidate, .bank_wr
    );

    glb_bank u_bank (
        .clk, .reset, .bank_wr, .rd_req_valid, .rd_req_ready, .rd_req_addr,
        .rd_data, .rd_valid
    );

endmodule

`default_nettype wire

// File: rtl/glb_bank.sv
// Single-port bank of 256 words. DMA writes win and stall host reads.
`timescale 1ns/1ps
`default_nettype none
`include "glb_consts.svh"

module glb_bank
    import glb_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  bank_wr_t   bank_wr,
    input  logic       rd_req_valid,
    output logic       rd_req_ready,
    input  bank_addr_t rd_req_addr,
    output data_t      rd_data,
    output logic       rd_valid
);

    data_t mem [2**`GLB_BANK_ADDR_WIDTH];
    logic  rd_fire;

    assign rd_req_ready = !bank_wr.en; // The single port is busy on a write.
    assign rd_fire      = rd_req_valid && rd_req_ready;

    always_ff @(posedge clk) begin
        if (bank_wr.en) begin
            mem[bank_wr.addr] <= bank_wr.data;
        end else if (rd_fire) begin
            rd_data <= mem[rd_req_addr];
        end
    end

    // Read data is valid for one cycle after the request is accepted.
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= rd_fire;
        end
    end

endmodule

`default_nettype wire

// File: rtl/glb_store_dma.sv
// Store DMA that writes a valid/ready stream into the bank under header control.
// Headers are served in queue order only while auto advance is on.
`timescale 1ns/1ps
`default_nettype none
`include "glb_consts.svh"

module glb_store_dma
    import glb_pkg::*;
(
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        dma_on,
    input  logic                        dma_auto_on,
    input  dma_header_t                 dma_header [`GLB_QUEUE_DEPTH],
    input  logic                        st_valid,
    input  data_t                       st_data,
    output logic                        st_ready,
    output logic [`GLB_QUEUE_DEPTH-1:0] dma_invalidate,
    output bank_wr_t                    bank_wr
);

    localparam int CURSOR_WIDTH = $clog2(`GLB_QUEUE_DEPTH);
    localparam logic [CURSOR_WIDTH-1:0] LAST_SLOT = CURSOR_WIDTH'(`GLB_QUEUE_DEPTH - 1);

    dma_state_t              state;
    logic [CURSOR_WIDTH-1:0] cursor;   // Header being served.
    num_words_t              word_cnt; // Words already written for this header.
    dma_header_t             cur_hdr;
    logic                    xfer;

    assign cur_hdr  = dma_header[cursor];
    assign st_ready = (state == dma_run) && cur_hdr.valid;
    assign xfer     = st_valid && st_ready;

    // Each accepted word goes to the bank on the same edge.
    always_comb begin
        bank_wr.en   = xfer;
        bank_wr.addr = cur_hdr.start_addr + bank_addr_t'(word_cnt);
        bank_wr.data = st_data;
    end

    always_comb begin
        dma_invalidate = '0;
        if (state == dma_done) begin
            dma_invalidate[cursor] = 1'b1; // One-cycle retire pulse.
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state    <= dma_idle;
            cursor   <= '0;
            word_cnt <= '0;
        end else begin
            case (state)
                dma_idle: begin
                    word_cnt <= '0;
                    if (dma_on && cur_hdr.valid) begin
                        // An empty header retires without touching the stream.
                        state <= (cur_hdr.num_words == '0) ? dma_done : dma_run;
                    end
                end
                dma_run: begin
                    if (xfer) begin
                        word_cnt <= word_cnt + 1'b1;
                        if (word_cnt == cur_hdr.num_words - 1'b1) begin
                            state <= dma_done;
                        end
                    end
                end
                dma_done: begin
                    state <= dma_idle;
                    if (dma_auto_on) begin
                        cursor <= (cursor == LAST_SLOT) ? '0 : cursor + 1'b1;
                    end else begin
                        cursor <= '0;
                    end
                end
                default: state <= dma_idle;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: rtl/glb_tile_cfg.sv
// Configuration registers and east/west router of one tile.
// A write to this tile in the same cycle as an invalidate pulse drops the pulse.
`timescale 1ns/1ps
`default_nettype none
`include "glb_consts.svh"

module glb_tile_cfg
    import glb_pkg::*;
(
    input  logic                        clk,
    input  logic                        reset,
    input  tile_id_t                    glb_tile_id,
    input  cfg_req_t                    cfg_east_req,
    output cfg_rsp_t                    cfg_east_rsp,
    output cfg_req_t                    cfg_west_req,
    input  cfg_rsp_t                    cfg_west_rsp,
    output logic                        tile_is_start,
    output logic                        tile_is_end,
    output logic                        dma_on,
    output logic                        dma_auto_on,
    output dma_header_t                 dma_header [`GLB_QUEUE_DEPTH],
    input  logic [`GLB_QUEUE_DEPTH-1:0] dma_invalidate
);

    tile_id_t                      wr_tile;
    tile_id_t                      rd_tile;
    logic [`GLB_REG_ADDR_WIDTH-1:0] wr_reg;
    logic [`GLB_REG_ADDR_WIDTH-1:0] rd_reg;
    logic                          wr_hit;
    logic                          rd_hit;
    cfg_data_t                     rd_value;

    // Register index of a header slot. The upper index holds valid and start address.
    function automatic logic [`GLB_REG_ADDR_WIDTH-1:0] hdr_reg(input int slot, input int upper);
        hdr_reg = `GLB_REG_ADDR_WIDTH'(`GLB_REG_HDR_BASE + 2 * slot + upper);
    endfunction

    // Address layout is tile id on top, then register index, then byte offset.
    assign wr_tile = cfg_east_req.wr_addr[`GLB_CFG_ADDR_WIDTH-1 -: `GLB_TILE_ID_WIDTH];
    assign rd_tile = cfg_east_req.rd_addr[`GLB_CFG_ADDR_WIDTH-1 -: `GLB_TILE_ID_WIDTH];
    assign wr_reg  = cfg_east_req.wr_addr[2 +: `GLB_REG_ADDR_WIDTH];
    assign rd_reg  = cfg_east_req.rd_addr[2 +: `GLB_REG_ADDR_WIDTH];

    assign wr_hit = cfg_east_req.wr_en && (wr_tile == glb_tile_id);
    assign rd_hit = cfg_east_req.rd_en && (rd_tile == glb_tile_id);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            tile_is_start <= 1'b0;
            tile_is_end   <= 1'b0;
            dma_on        <= 1'b0;
            dma_auto_on   <= 1'b0;
            for (int i = 0; i < `GLB_QUEUE_DEPTH; i++) begin
                dma_header[i] <= '0;
            end
        end else if (wr_hit) begin
            case (wr_reg)
                `GLB_REG_TILE_CTRL: {tile_is_end, tile_is_start} <= cfg_east_req.wr_data[1:0];
                `GLB_REG_DMA_CTRL:  {dma_auto_on, dma_on} <= cfg_east_req.wr_data[1:0];
                default: ;
            endcase
            for (int i = 0; i < `GLB_QUEUE_DEPTH; i++) begin
                if (wr_reg == hdr_reg(i, 0)) begin
                    dma_header[i].num_words <= cfg_east_req.wr_data[`GLB_NUM_WORDS_WIDTH-1:0];
                end
                if (wr_reg == hdr_reg(i, 1)) begin
                    {dma_header[i].start_addr, dma_header[i].valid} <=
                        cfg_east_req.wr_data[`GLB_BANK_ADDR_WIDTH:0];
                end
            end
        end else begin
            // The DMA retires a header by clearing only its valid bit.
            for (int i = 0; i < `GLB_QUEUE_DEPTH; i++) begin
                if (dma_invalidate[i]) begin
                    dma_header[i].valid <= 1'b0;
                end
            end
        end
    end

    // Read mux. Unmapped indices read as zero.
    always_comb begin
        rd_value = '0;
        case (rd_reg)
            `GLB_REG_TILE_CTRL: rd_value = cfg_data_t'({tile_is_end, tile_is_start});
            `GLB_REG_DMA_CTRL:  rd_value = cfg_data_t'({dma_auto_on, dma_on});
            default: ;
        endcase
        for (int i = 0; i < `GLB_QUEUE_DEPTH; i++) begin
            if (rd_reg == hdr_reg(i, 0)) begin
                rd_value = cfg_data_t'(dma_header[i].num_words);
            end
            if (rd_reg == hdr_reg(i, 1)) begin
                rd_value = cfg_data_t'({dma_header[i].start_addr, dma_header[i].valid});
            end
        end
    end

    // Requests for other tiles move one hop west. Idle cycles send all zero.
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cfg_west_req <= '0;
        end else begin
            cfg_west_req <= '0;
            if (cfg_east_req.wr_en && !wr_hit) begin
                cfg_west_req.wr_en   <= 1'b1;
                cfg_west_req.wr_addr <= cfg_east_req.wr_addr;
                cfg_west_req.wr_data <= cfg_east_req.wr_data;
            end
            if (cfg_east_req.rd_en && !rd_hit) begin
                cfg_west_req.rd_en   <= 1'b1;
                cfg_west_req.rd_addr <= cfg_east_req.rd_addr;
            end
        end
    end

    // A local read response takes the slot, otherwise the west response passes east.
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cfg_east_rsp <= '0;
        end else if (rd_hit) begin
            cfg_east_rsp.rd_data       <= rd_value;
            cfg_east_rsp.rd_data_valid <= 1'b1;
        end else begin
            cfg_east_rsp <= cfg_west_rsp;
        end
    end

endmodule

`default_nettype wire

// File: rtl/glb_pkg.sv
// Shared types of the global buffer tile. Widths come from glb_consts.svh.
`default_nettype none
`include "glb_consts.svh"

package glb_pkg;

    typedef logic [`GLB_TILE_ID_WIDTH-1:0] tile_id_t;
    typedef logic [`GLB_CFG_DATA_WIDTH-1:0] cfg_data_t;
    typedef logic [`GLB_CFG_ADDR_WIDTH-1:0] cfg_addr_t;
    typedef logic [`GLB_BANK_ADDR_WIDTH-1:0] bank_addr_t;
    typedef logic [`GLB_DATA_WIDTH-1:0] data_t;
    typedef logic [`GLB_NUM_WORDS_WIDTH-1:0] num_words_t;

    // One request on the daisy-chained configuration bus.
    typedef struct packed {
        logic      wr_en;
        cfg_addr_t wr_addr;
        cfg_data_t wr_data;
        logic      rd_en;
        cfg_addr_t rd_addr;
    } cfg_req_t;

    typedef struct packed {
        cfg_data_t rd_data;
        logic      rd_data_valid;
    } cfg_rsp_t;

    typedef struct packed {
        logic       valid;
        bank_addr_t start_addr;
        num_words_t num_words;
    } dma_header_t;

    typedef enum logic [1:0] {dma_idle, dma_run, dma_done} dma_state_t;

    typedef struct packed {
        logic       en;
        bank_addr_t addr;
        data_t      data;
    } bank_wr_t;

endpackage

`default_nettype wire

// File: rtl/glb_consts.svh
// Widths, queue depth and register map of one global buffer tile.
// Header registers use two indices per slot, starting at GLB_REG_HDR_BASE.
`ifndef GLB_CONSTS_SVH
`define GLB_CONSTS_SVH

// Configuration bus.
`define GLB_CFG_DATA_WIDTH 32
`define GLB_CFG_ADDR_WIDTH 11
`define GLB_TILE_ID_WIDTH 4   // Address bits 10 to 7.
`define GLB_REG_ADDR_WIDTH 5  // Address bits 6 to 2.

// Store DMA and bank.
`define GLB_QUEUE_DEPTH 4
`define GLB_BANK_ADDR_WIDTH 8 // 256 words per bank.
`define GLB_DATA_WIDTH 16
`define GLB_NUM_WORDS_WIDTH 8

// Register indices.
`define GLB_REG_TILE_CTRL 0   // Bit 0 is tile start and bit 1 is tile end.
`define GLB_REG_DMA_CTRL 1    // Bit 0 is DMA on and bit 1 is auto advance.
`define GLB_REG_HDR_BASE 2

`endif
